// File: src/arm_exec_defs.svh
`ifndef ARM_EXEC_DEFS_SVH
`define ARM_EXEC_DEFS_SVH

// architectural word width
`define ARM_WORD_W 32

// register file size and index width
`define ARM_REG_COUNT 16
`define ARM_REG_AW 4

// data memory depth in words
`define ARM_DMEM_WORDS 64
// word index bits taken above address bit 1
`define ARM_DMEM_AW 6

// number of status flags, NZCV
`define ARM_FLAG_W 4

`endif

// File: src/arm_exec_pkg.sv
`default_nettype none

`include "arm_exec_defs.svh"

package arm_exec_pkg;

    // bits 27:26 of the instruction word
    typedef enum logic [1:0] {
        CLS_DP = 2'b00, // data processing
        CLS_LS = 2'b01  // single word load/store
    } instr_class_t;

    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } dp_opcode_t;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shift_kind_t;

    // data processing view
    // operand2 is {rot, imm8} when imm is set, else {shamt, kind, 1'b0, rm}
    typedef struct packed {
        logic [3:0]             cond;      // not evaluated
        instr_class_t           cls;
        logic                   imm;
        dp_opcode_t             opcode;
        logic                   set_flags;
        logic [`ARM_REG_AW-1:0] rn;
        logic [`ARM_REG_AW-1:0] rd;
        logic [11:0]            operand2;
    } dp_fields_t;

    // load/store view
    typedef struct packed {
        logic [3:0]             cond;
        instr_class_t           cls;
        logic                   imm;       // 0 for immediate offset
        logic                   pre;
        logic                   up;        // add or subtract offset
        logic                   byte_acc;
        logic                   wback;
        logic                   load;      // LDR when set
        logic [`ARM_REG_AW-1:0] rn;
        logic [`ARM_REG_AW-1:0] rd;
        logic [11:0]            offset;
    } ls_fields_t;

    typedef union packed {
        dp_fields_t dp;
        ls_fields_t ls;
    } instr_word_t;

    // what each unit hands back to the register block
    typedef struct packed {
        logic                   we;
        logic [`ARM_REG_AW-1:0] rd;
        logic [`ARM_WORD_W-1:0] value;
        logic                   flags_we;
        logic [`ARM_FLAG_W-1:0] nzcv;
    } unit_result_t;

endpackage

`default_nettype wire

// File: src/exec_operands_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "arm_exec_defs.svh"

interface exec_operands_if;
    import arm_exec_pkg::*;

    logic                   valid;  // one cycle per accepted instruction
    instr_word_t            instr;
    logic [`ARM_WORD_W-1:0] rn_val;
    logic [`ARM_WORD_W-1:0] rm_val;
    logic [`ARM_WORD_W-1:0] rd_val; // store data
    logic [`ARM_FLAG_W-1:0] flags;  // current NZCV

    modport source (
        output valid, instr, rn_val, rm_val, rd_val, flags
    );

    modport sink (
        input valid, instr, rn_val, rm_val, rd_val, flags
    );

endinterface

`default_nettype wire

// File: src/alu_shift_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "arm_exec_defs.svh"

module alu_shift_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    exec_operands_if.sink             ops,
    output arm_exec_pkg::unit_result_t res
);
    import arm_exec_pkg::*;

    logic [`ARM_WORD_W-1:0] op1;
    logic [`ARM_WORD_W-1:0] rm;
    logic                   old_c;
    logic                   old_v;

    // immediate form
    logic [4:0]             rot_amt;
    logic [63:0]            rot_ext;

    // register form
    logic [4:0]             shamt;
    logic [5:0]             sh_amt;   // 0 becomes 32 for LSR/ASR
    shift_kind_t            sh_kind;
    logic [32:0]            lsl_ext;
    logic [32:0]            lsr_ext;
    logic [32:0]            asr_ext;
    logic [63:0]            ror_ext;

    logic [`ARM_WORD_W-1:0] op2;
    logic                   shift_c;

    logic [32:0]            sum;
    logic [`ARM_WORD_W-1:0] alu_val;
    logic                   alu_c;
    logic                   alu_v;
    logic                   known_op;
    logic                   writes_rd;
    logic                   is_dp;
    logic                   upd_flags;

    assign op1   = ops.rn_val;
    assign rm    = ops.rm_val;
    assign old_c = ops.flags[1];
    assign old_v = ops.flags[0];

    assign rot_amt = {ops.instr.dp.operand2[11:8], 1'b0};
    assign rot_ext = {24'b0, ops.instr.dp.operand2[7:0],
                      24'b0, ops.instr.dp.operand2[7:0]} >> rot_amt;

    assign shamt   = ops.instr.dp.operand2[11:7];
    assign sh_kind = shift_kind_t'(ops.instr.dp.operand2[6:5]);
    assign sh_amt  = (shamt == 5'd0) ? 6'd32 : {1'b0, shamt};

    assign lsl_ext = {old_c, rm} << shamt;          // bit 32 is carry out
    assign lsr_ext = {rm, 1'b0} >> sh_amt;          // bit 0 is carry out
    assign asr_ext = $signed({rm, 1'b0}) >>> sh_amt;
    assign ror_ext = {rm, rm} >> shamt;

    // barrel shifter
    always_comb begin
        if (ops.instr.dp.imm) begin
            op2     = rot_ext[31:0];
            shift_c = (rot_amt != 5'd0) ? rot_ext[31] : old_c;
        end else begin
            case (sh_kind)
                SH_LSL: begin
                    op2     = lsl_ext[31:0];
                    shift_c = lsl_ext[32];
                end
                SH_LSR: begin
                    op2     = lsr_ext[32:1];
                    shift_c = lsr_ext[0];
                end
                SH_ASR: begin
                    op2     = asr_ext[32:1];
                    shift_c = asr_ext[0];
                end
                default: begin
                    op2     = ror_ext[31:0];
                    shift_c = (shamt == 5'd0) ? old_c : ror_ext[31];
                end
            endcase
        end
    end

    always_comb begin
        sum       = '0;
        alu_val   = op2;
        alu_c     = shift_c;   // logical ops take the shifter carry
        alu_v     = old_v;
        known_op  = 1'b1;
        writes_rd = 1'b1;
        case (ops.instr.dp.opcode)
            OP_AND: alu_val = op1 & op2;
            OP_ORR: alu_val = op1 | op2;
            OP_MOV: alu_val = op2;
            OP_ADD: begin
                sum     = {1'b0, op1} + {1'b0, op2};
                alu_val = sum[31:0];
                alu_c   = sum[32];
                alu_v   = (op1[31] == op2[31]) && (sum[31] != op1[31]);
            end
            OP_SUB, OP_CMP: begin
                sum       = {1'b0, op1} + {1'b0, ~op2} + 33'd1;
                alu_val   = sum[31:0];
                alu_c     = sum[32];   // set when no borrow
                alu_v     = (op1[31] != op2[31]) && (sum[31] != op1[31]);
                writes_rd = (ops.instr.dp.opcode != OP_CMP);
            end
            default: begin
                known_op  = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
    end

    assign is_dp     = ops.valid && (ops.instr.dp.cls == CLS_DP);
    assign upd_flags = is_dp && known_op &&
                       (ops.instr.dp.set_flags || ops.instr.dp.opcode == OP_CMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res.we       <= is_dp && writes_rd;
            res.rd       <= ops.instr.dp.rd;
            res.value    <= alu_val;
            res.flags_we <= upd_flags;
            // unchanged flags pass through when not written
            res.nzcv     <= upd_flags ? {alu_val[31], alu_val == '0, alu_c, alu_v}
                                      : ops.flags;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_access_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "arm_exec_defs.svh"

module mem_access_unit (
    input  logic                      clk,
    exec_operands_if.sink             ops,
    output arm_exec_pkg::unit_result_t res
);
    import arm_exec_pkg::*;

    logic [`ARM_WORD_W-1:0] dmem [`ARM_DMEM_WORDS];

    logic [`ARM_WORD_W-1:0] offset;
    logic [`ARM_WORD_W-1:0] addr;
    logic [`ARM_DMEM_AW-1:0] word_idx;
    logic                   is_ls;
    logic                   do_store;
    logic                   do_load;

    assign offset   = {{(`ARM_WORD_W-12){1'b0}}, ops.instr.ls.offset};
    assign addr     = ops.instr.ls.up ? (ops.rn_val + offset)
                                      : (ops.rn_val - offset);
    assign word_idx = addr[`ARM_DMEM_AW+1:2]; // wraps at memory depth

    assign is_ls    = ops.valid && (ops.instr.ls.cls == CLS_LS);
    assign do_store = is_ls && !ops.instr.ls.load;
    assign do_load  = is_ls && ops.instr.ls.load;

    // store data is the rd operand
    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[word_idx] <= ops.rd_val;
        end
    end

    // synchronous read, lands together with the ALU result
    always_ff @(posedge clk) begin
        res.we       <= do_load;
        res.rd       <= ops.instr.ls.rd;
        res.value    <= dmem[word_idx];
        res.flags_we <= 1'b0;       // loads never touch NZCV
        res.nzcv     <= ops.flags;
    end

endmodule

`default_nettype wire

// File: src/reg_writeback.sv
`default_nettype none
`timescale 1ns/1ps

`include "arm_exec_defs.svh"

module reg_writeback (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  arm_exec_pkg::instr_word_t    instr,
    input  logic [`ARM_REG_AW-1:0]       reg_addr,
    output logic [`ARM_WORD_W-1:0]       reg_output,
    output logic [`ARM_FLAG_W-1:0]       status_out,
    output logic                         busy,
    exec_operands_if.source              ops,
    input  arm_exec_pkg::unit_result_t   alu_res,
    input  arm_exec_pkg::unit_result_t   mem_res
);
    import arm_exec_pkg::*;

    logic [`ARM_WORD_W-1:0] regs [`ARM_REG_COUNT];
    logic [`ARM_FLAG_W-1:0] flags;
    logic [1:0]             busy_cnt;  // 2 after accept, 1 during unit edge
    logic                   accept;

    assign accept = instr_valid && !busy;
    assign busy   = (busy_cnt != 2'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= 2'd0;
        end else if (accept) begin
            busy_cnt <= 2'd2;
        end else if (busy_cnt != 2'd0) begin
            busy_cnt <= busy_cnt - 2'd1;
        end
    end

    // operand issue, one cycle strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ops.valid <= 1'b0;
        end else begin
            ops.valid <= accept;
        end
    end

    // rn and rd sit at the same bits in both views
    always_ff @(posedge clk) begin
        if (accept) begin
            ops.instr  <= instr;
            ops.rn_val <= regs[instr.dp.rn];
            ops.rm_val <= regs[instr.dp.operand2[3:0]];
            ops.rd_val <= regs[instr.dp.rd];
        end
    end

    assign ops.flags = flags;

    // writeback, the units never both write in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ARM_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (alu_res.we) begin
                regs[alu_res.rd] <= alu_res.value;
            end else if (mem_res.we) begin
                regs[mem_res.rd] <= mem_res.value;
            end
            if (alu_res.flags_we) begin  // only the ALU sets flags
                flags <= alu_res.nzcv;
            end
        end
    end

    assign reg_output = regs[reg_addr];
    assign status_out = flags;

endmodule

`default_nettype wire

// File: src/arm_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "arm_exec_defs.svh"

module arm_exec_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [`ARM_WORD_W-1:0] instr,
    input  logic [`ARM_REG_AW-1:0] reg_addr,
    output logic [`ARM_WORD_W-1:0] reg_output,
    output logic [`ARM_FLAG_W-1:0] status_out,
    output logic                   busy
);
    import arm_exec_pkg::*;

    unit_result_t alu_res;
    unit_result_t mem_res;

    // operands shared by both units
    exec_operands_if ops_if ();

    reg_writeback u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .reg_addr    (reg_addr),
        .reg_output  (reg_output),
        .status_out  (status_out),
        .busy        (busy),
        .ops         (ops_if.source),
        .alu_res     (alu_res),
        .mem_res     (mem_res)
    );

    alu_shift_unit u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .ops   (ops_if.sink),
        .res   (alu_res)
    );

    // memory holds no reset
    mem_access_unit u_mem (
        .clk (clk),
        .ops (ops_if.sink),
        .res (mem_res)
    );

endmodule

`default_nettype wire

// File: testbench/arm_exec_props.sv
`default_nettype none
`timescale 1ns/1ps

module arm_exec_props (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic busy
);
    logic accept;

    assign accept = instr_valid && !busy;

    busy_rise: assert property (@(posedge clk) disable iff (!rst_n) accept |=> busy)
        else $error("busy did not rise after an accepted instruction");

    // high for exactly two sampled cycles
    busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ##1 busy ##1 !busy)
        else $error("busy did not fall two cycles after the accept");

    no_valid_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !instr_valid)
        else $error("instr_valid pulsed while busy was high");

    busy_low_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !busy)
        else $error("busy high during reset");

endmodule

bind arm_exec_top arm_exec_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .busy        (busy)
);

`default_nettype wire

// File: testbench/tb_arm_exec.sv
`default_nettype none
`timescale 1ns/1ps

`include "arm_exec_defs.svh"

module tb_arm_exec;
    import arm_exec_pkg::*;

    localparam int N_RANDOM    = 200;
    localparam int N_INSTR     = 100 + N_RANDOM;  // directed phases stay below 100
    localparam int WATCHDOG_NS = (10 + N_INSTR * (3 + `ARM_REG_COUNT + 5)) * 10;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    logic [`ARM_WORD_W-1:0] instr;
    logic [3:0]             reg_addr;
    logic [`ARM_WORD_W-1:0] reg_output;
    logic [3:0]             status_out;
    logic                   busy;

    // reference state
    logic [`ARM_WORD_W-1:0] m_regs [`ARM_REG_COUNT];
    logic [3:0]             m_flags;
    logic [`ARM_WORD_W-1:0] m_mem [`ARM_DMEM_WORDS];
    int                     stored_idx [$];  // word indices written so far

    dp_opcode_t alu_ops [4] = '{OP_ADD, OP_SUB, OP_AND, OP_ORR};
    dp_opcode_t six_ops [6] = '{OP_AND, OP_SUB, OP_ADD, OP_CMP, OP_ORR, OP_MOV};

    integer seed        = 32'hf765e77d;
    int     error_count = 0;
    int     instr_count = 0;
    event   sweep_req;
    event   sweep_done;

    arm_exec_top dut_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] encode_dp(input logic [3:0] op, input logic s,
                                              input logic i, input logic [3:0] rn,
                                              input logic [3:0] rd, input logic [11:0] op2);
        return {4'he, 2'b00, i, op, s, rn, rd, op2};
    endfunction

    // immediate offset, pre-indexed, no writeback
    function automatic logic [31:0] encode_ls(input logic load, input logic up,
                                              input logic [3:0] rn, input logic [3:0] rd,
                                              input logic [11:0] off);
        return {4'he, 2'b01, 1'b0, 1'b1, up, 2'b00, load, rn, rd, off};
    endfunction

    function automatic void ref_exec(input logic [31:0] w);
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rm_v;
        logic [31:0] res;
        logic [32:0] wide;
        logic [31:0] addr;
        logic        c_in;
        logic        sh_c;
        logic        c_out;
        logic        v_out;
        int          amt;
        int          idx;

        op   = w[24:21];
        rd   = w[15:12];
        a    = m_regs[w[19:16]];
        c_in = m_flags[1];
        if (w[27:26] == 2'b01) begin
            addr = w[23] ? a + {20'd0, w[11:0]} : a - {20'd0, w[11:0]};
            idx  = int'((addr >> 2) % `ARM_DMEM_WORDS);
            if (w[20]) begin
                m_regs[rd] = m_mem[idx];
            end else begin
                m_mem[idx] = m_regs[rd];
                stored_idx.push_back(idx);
            end
            return;
        end
        if (w[25]) begin  // 8-bit immediate, rotated right by twice the field
            amt = 2 * int'(w[11:8]);
            b   = {24'd0, w[7:0]};
            if (amt != 0) b = (b >> amt) | (b << (32 - amt));
            sh_c = (amt != 0) ? b[31] : c_in;
        end else begin
            rm_v = m_regs[w[3:0]];
            amt  = int'(w[11:7]);
            case (w[6:5])
                2'b00: begin
                    b    = rm_v << amt;
                    sh_c = (amt == 0) ? c_in : rm_v[32 - amt];
                end
                2'b01, 2'b10: begin
                    if (amt == 0) amt = 32;  // shift by 32 encoded as 0
                    b    = rm_v >> amt;
                    if (w[6] && rm_v[31]) b = b | ~(32'hffff_ffff >> amt);
                    sh_c = rm_v[amt - 1];
                end
                default: begin
                    b    = (amt == 0) ? rm_v : (rm_v >> amt) | (rm_v << (32 - amt));
                    sh_c = (amt == 0) ? c_in : b[31];
                end
            endcase
        end
        c_out = sh_c;
        v_out = m_flags[0];
        case (op)
            OP_AND: res = a & b;
            OP_ORR: res = a | b;
            OP_MOV: res = b;
            OP_ADD: begin
                wide  = {1'b0, a} + {1'b0, b};
                res   = wide[31:0];
                c_out = wide[32];
                v_out = (a[31] ~^ b[31]) & (res[31] ^ a[31]);
            end
            OP_SUB, OP_CMP: begin
                res   = a - b;
                c_out = (a >= b);  // carry means no borrow
                v_out = (a[31] ^ b[31]) & (res[31] ^ a[31]);
            end
            default: return;       // unassigned opcodes do nothing
        endcase
        if (op != OP_CMP) m_regs[rd] = res;
        if (w[20] || op == OP_CMP) m_flags = {res[31], res == 32'd0, c_out, v_out};
    endfunction

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = w;
        reg_addr    = w[15:12];  // destination register, seen right at writeback
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        if (busy !== 1'b1) begin
            error_count++;
            $display("busy did not rise after instruction %h was accepted", w);
        end
        while (busy) begin  // writeback edge passed once busy drops
            @(posedge clk);
            #1;
        end
        ref_exec(w);
        if (reg_output !== m_regs[w[15:12]]) begin
            error_count++;
            $display("mismatch reg_output r%0d at writeback: dut %h, ref %h",
                     w[15:12], reg_output, m_regs[w[15:12]]);
        end
        instr_count++;
        -> sweep_req;
        @(sweep_done);
    endtask

    // compare process, sweeps the debug port after each writeback
    initial begin
        forever begin
            @(sweep_req);
            for (int i = 0; i < `ARM_REG_COUNT; i++) begin
                @(posedge clk);
                #1;
                reg_addr = 4'(i);
                #4;
                if (reg_output !== m_regs[i]) begin
                    error_count++;
                    $display("mismatch reg_output r%0d: dut %h, ref %h", i, reg_output, m_regs[i]);
                end
            end
            if (status_out !== m_flags) begin
                error_count++;
                $display("mismatch status_out: dut %h, ref %h", status_out, m_flags);
            end
            -> sweep_done;
        end
    end

    initial begin
        int          k;
        int          k2;
        logic [5:0]  t;
        logic [3:0]  op;
        logic [11:0] op2;
        logic [11:0] off;

        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        reg_addr    = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
        m_flags = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (busy !== 1'b0) begin
            error_count++;
            $display("busy is not low after reset");
        end
        -> sweep_req;
        @(sweep_done);

        for (int r = 0; r < 16; r++) begin  // every rotate value
            issue(encode_dp(OP_MOV, r[0], 1'b1, 4'd0, 4'(r % 13), {4'(r), 8'h81 ^ 8'(r * 37)}));
        end

        // each op with each shift kind, amount zero and nonzero, S clear and set
        for (int n = 0; n < 64; n++) begin
            k   = $random(seed);
            op2 = {n[1] ? k[28:24] : 5'd0, n[3:2], 1'b0, k[23:20]};
            issue(encode_dp(alu_ops[n / 16], n[0], 1'b0, k[19:16], 4'(k[11:8] % 13), op2));
        end

        issue(encode_dp(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd1, 12'h005));
        issue(encode_dp(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd2, 12'h009));
        issue(encode_dp(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd3, 12'h4ff));  // negative word
        issue(encode_dp(OP_CMP, 1'b1, 1'b0, 4'd1, 4'd0, 12'h001));  // equal
        issue(encode_dp(OP_CMP, 1'b1, 1'b0, 4'd1, 4'd0, 12'h002));  // less
        issue(encode_dp(OP_CMP, 1'b1, 1'b0, 4'd2, 4'd0, 12'h001));  // greater
        issue(encode_dp(OP_CMP, 1'b1, 1'b0, 4'd3, 4'd0, 12'h001));
        issue(encode_dp(OP_CMP, 1'b0, 1'b0, 4'd1, 4'd0, 12'h003));

        // r14 holds the window base 0x100 from here on
        issue(encode_dp(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd14, 12'hc01));
        issue(encode_ls(1'b0, 1'b1, 4'd14, 4'd3, 12'h020));
        issue(encode_ls(1'b1, 1'b1, 4'd14, 4'd4, 12'h020));
        issue(encode_ls(1'b0, 1'b0, 4'd14, 4'd1, 12'h010));
        issue(encode_ls(1'b1, 1'b0, 4'd14, 4'd5, 12'h010));

        for (int n = 0; n < N_RANDOM; n++) begin
            k  = $random(seed);
            k2 = $random(seed);
            if (k[31:29] <= 3'd1) begin
                t = k[5:0];
                if (k[29] && stored_idx.size() != 0) begin
                    t = 6'(stored_idx[$unsigned(k2) % stored_idx.size()]);
                end
                off = k[28] ? {4'd0, t, 2'b00} : 12'h100 - {4'd0, t, 2'b00};
                if (k[29] && stored_idx.size() != 0) begin
                    issue(encode_ls(1'b1, k[28], 4'd14, 4'(k[15:12] % 13), off));
                end else begin
                    issue(encode_ls(1'b0, k[28], 4'd14, k[15:12], off));
                end
            end else begin
                op  = k2[4] ? k2[3:0] : six_ops[k2[7:5] % 6];
                op2 = k[26] ? k[11:0] : {k[11:5], 1'b0, k[3:0]};
                issue(encode_dp(op, k[20], k[26], k[19:16], 4'(k[15:12] % 13), op2));
            end
        end

        $display("instructions: %0d, errors: %0d", instr_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d instructions, the DUT stopped responding",
                 instr_count);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/arm_exec_pkg.sv
src/exec_operands_if.sv
src/alu_shift_unit.sv
src/mem_access_unit.sv
src/reg_writeback.sv
src/arm_exec_top.sv
testbench/arm_exec_props.sv
testbench/tb_arm_exec.sv

// File: Bender.yml
package:
  name: arm_exec

export_include_dirs:
  - src

sources:
  - files:
      - src/arm_exec_pkg.sv
      - src/exec_operands_if.sv
      - src/alu_shift_unit.sv
      - src/mem_access_unit.sv
      - src/reg_writeback.sv
      - src/arm_exec_top.sv
  - target: test
    files:
      - testbench/arm_exec_props.sv
      - testbench/tb_arm_exec.sv
